/* files.f */
+incdir+hdl
hdl/uart_pkg.sv
hdl/frame_pkg.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/frame_tx.sv
hdl/frame_rx.sv
hdl/uart_frame_top.sv
sim/tb_uart_frame.sv

/* hdl/frame_pkg.sv */
//********************************************************************
// string frame types
// message and length as seen by the framers, the top level and
// the testbench
//********************************************************************
`include "uart_config.svh"

package frame_pkg;

	// content length in bytes, 0 to MAX_CHARS
	typedef logic [`LEN_W-1:0] frame_len_t;

	// content bytes, byte 0 in the lowest bits and sent first
	typedef logic [`MAX_CHARS-1:0][7:0] frame_chars_t;

	// a complete message with its length
	typedef struct packed {
		frame_len_t   len;
		frame_chars_t chars;
	} frame_msg_t;

endpackage

/* hdl/frame_rx.sv */
//********************************************************************
// receive deframer
// hunts for "&&", collects content up to the closing "&&" and
// flags overflow, lone markers and bad stop bits
//********************************************************************
`timescale 1ns/1ps
`include "uart_config.svh"

module frame_rx
	import uart_pkg::*;
	import frame_pkg::*;
(
	input  logic          sys_clk,
	input  logic          sys_rst_n,
	input  uart_rx_beat_t rx_beat,
	output frame_msg_t    rx_msg,
	output logic          rx_busy,
	output logic          rx_done,
	output logic          rx_err
);

	localparam int         IDX_W   = $clog2(`MAX_CHARS);
	localparam frame_len_t MAX_LEN = frame_len_t'(`MAX_CHARS);

	typedef enum logic [1:0] {
		RX_HUNT,
		RX_OPEN1,
		RX_CONTENT,
		RX_CLOSE1
	} rx_state_t;

	rx_state_t    state;
	frame_len_t   wlen;
	frame_chars_t wbuf;
	// an aborted frame still owes its closing "&&", which must not open a new one
	logic         drop_close;
	logic         is_mark;
	logic         good_mark;
	logic         beat_err;
	logic         beat_close;
	logic         beat_store;
	logic         beat_open;

	assign is_mark   = (rx_beat.data == `FRAME_MARK);
	assign good_mark = is_mark && !rx_beat.stop_err;

	assign beat_err = rx_beat.vld && (
		(state == RX_CONTENT && (rx_beat.stop_err || (!is_mark && wlen == MAX_LEN))) ||
		(state == RX_CLOSE1 && !good_mark));
	assign beat_close = rx_beat.vld && (state == RX_CLOSE1) && good_mark;
	assign beat_store = rx_beat.vld && (state == RX_CONTENT) && !is_mark && !beat_err;
	assign beat_open  = rx_beat.vld && (state == RX_OPEN1) && good_mark && !drop_close;

	assign rx_busy = (state != RX_HUNT);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state      <= RX_HUNT;
			wlen       <= '0;
			drop_close <= 1'b0;
			rx_done    <= 1'b0;
			rx_err     <= 1'b0;
		end else begin
			rx_done <= beat_close;
			rx_err  <= beat_err;
			if (beat_err) begin
				state      <= RX_HUNT;
				drop_close <= 1'b1;
			end else if (rx_beat.vld) begin
				case (state)
					RX_HUNT: if (good_mark)
						state <= RX_OPEN1;
					// a lone "&" outside a frame is just noise
					RX_OPEN1: begin
						if (beat_open) begin
							state <= RX_CONTENT;
							wlen  <= '0;
						end else begin
							state <= RX_HUNT;
						end
						if (good_mark)
							drop_close <= 1'b0;
					end
					RX_CONTENT: if (is_mark)
						state <= RX_CLOSE1;
					else
						wlen <= wlen + frame_len_t'(1);
					RX_CLOSE1: state <= RX_HUNT;
					default: state <= RX_HUNT;
				endcase
			end
		end
	end

	// working buffer starts empty so bytes above len read as zero
	always_ff @(posedge sys_clk) begin
		if (beat_open || beat_err)
			wbuf <= '0;
		else if (beat_store)
			wbuf[wlen[IDX_W-1:0]] <= rx_beat.data;
		if (beat_close) begin
			rx_msg.len   <= wlen;
			rx_msg.chars <= wbuf;
		end
	end

endmodule

/* hdl/frame_tx.sv */
//********************************************************************
// transmit framer
// sends "&&", the content bytes and "&&" through the serializer
//********************************************************************
`timescale 1ns/1ps
`include "uart_config.svh"

module frame_tx
	import uart_pkg::*;
	import frame_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       tx_req,
	input  frame_msg_t tx_msg,
	output logic       tx_busy,
	output logic       tx_done,
	output logic       byte_req,
	output uart_byte_t byte_data,
	input  logic       byte_done
);

	localparam int IDX_W = $clog2(`MAX_CHARS);

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_MARK1,
		TX_MARK2,
		TX_CONTENT,
		TX_MARK3,
		TX_MARK4
	} tx_state_t;

	tx_state_t  state;
	frame_msg_t msg_q;
	// index of the next content byte to queue
	frame_len_t cnt;
	logic       start;

	assign start   = (state == TX_IDLE) && tx_req;
	assign tx_busy = (state != TX_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= TX_IDLE;
			cnt      <= '0;
			byte_req <= 1'b0;
			tx_done  <= 1'b0;
		end else begin
			byte_req <= 1'b0;
			tx_done  <= 1'b0;
			case (state)
				TX_IDLE: if (tx_req) begin
					state    <= TX_MARK1;
					cnt      <= '0;
					byte_req <= 1'b1;
				end
				TX_MARK1: if (byte_done) begin
					state    <= TX_MARK2;
					byte_req <= 1'b1;
				end
				// empty strings go straight to the closing markers
				TX_MARK2: if (byte_done) begin
					byte_req <= 1'b1;
					if (msg_q.len == '0) begin
						state <= TX_MARK3;
					end else begin
						state <= TX_CONTENT;
						cnt   <= frame_len_t'(1);
					end
				end
				TX_CONTENT: if (byte_done) begin
					byte_req <= 1'b1;
					if (cnt == msg_q.len)
						state <= TX_MARK3;
					else
						cnt <= cnt + frame_len_t'(1);
				end
				TX_MARK3: if (byte_done) begin
					state    <= TX_MARK4;
					byte_req <= 1'b1;
				end
				TX_MARK4: if (byte_done) begin
					state   <= TX_IDLE;
					tx_done <= 1'b1;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// byte to send, set up together with each request
	always_ff @(posedge sys_clk) begin
		if (start) begin
			msg_q     <= tx_msg;
			byte_data <= `FRAME_MARK;
		end else if (byte_done) begin
			case (state)
				TX_MARK2:
					byte_data <= (msg_q.len == '0) ? `FRAME_MARK : msg_q.chars[0];
				TX_CONTENT:
					byte_data <= (cnt == msg_q.len) ? `FRAME_MARK
						: msg_q.chars[cnt[IDX_W-1:0]];
				default:
					byte_data <= `FRAME_MARK;
			endcase
		end
	end

endmodule

/* hdl/uart_config.svh */
//********************************************************************
// uart framing configuration
// clock and line rates, bit period, string size and marker character
//********************************************************************
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

// system clock and serial line rate
`define SYS_CLK_HZ    250_000_000
`define BAUD_RATE     15_625_000

// clock cycles per serial bit, 16 at the rates above
`define CLKS_PER_BIT  (`SYS_CLK_HZ / `BAUD_RATE)

// largest content length in bytes
`define MAX_CHARS     16

// width of a length field, holds 0 to MAX_CHARS
`define LEN_W         5

// frame marker, ascii "&"
`define FRAME_MARK    8'h26

`endif

/* hdl/uart_frame_top.sv */
//********************************************************************
// uart string framing subsystem
// framers on top of the byte serializer and deserializer
//********************************************************************
`timescale 1ns/1ps

module uart_frame_top
	import uart_pkg::*;
	import frame_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	// transmit side
	input  logic       tx_req,
	input  frame_msg_t tx_msg,
	output logic       tx_busy,
	output logic       tx_done,
	// receive side
	output frame_msg_t rx_msg,
	output logic       rx_busy,
	output logic       rx_done,
	output logic       rx_err,
	// serial line
	input  logic       uart_rx_port,
	output logic       uart_tx_port
);

	logic          byte_req;
	uart_byte_t    byte_data;
	logic          byte_done;
	uart_rx_beat_t rx_beat;

	frame_tx u_frame_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_req    (tx_req),
		.tx_msg    (tx_msg),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_req  (byte_req),
		.byte_data (byte_data),
		.byte_done (byte_done)
	);

	uart_tx u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.byte_req  (byte_req),
		.byte_data (byte_data),
		.line      (uart_tx_port),
		.byte_done (byte_done)
	);

	uart_rx u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.line      (uart_rx_port),
		.rx_beat   (rx_beat)
	);

	frame_rx u_frame_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_beat   (rx_beat),
		.rx_msg    (rx_msg),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.rx_err    (rx_err)
	);

endmodule

/* hdl/uart_pkg.sv */
//********************************************************************
// uart serial-line types
// shared by the byte serializer, the deserializer and the framers
//********************************************************************
package uart_pkg;

	// one character on the line
	typedef logic [7:0] uart_byte_t;

	// one received byte as reported by the deserializer
	typedef struct packed {
		// one-cycle strobe
		logic       vld;
		// received character
		uart_byte_t data;
		// stop bit was sampled low
		logic       stop_err;
	} uart_rx_beat_t;

endpackage

/* hdl/uart_rx.sv */
//********************************************************************
// uart byte deserializer
// two-flop synchronizer, mid-bit sampling and stop bit check
//********************************************************************
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_rx
	import uart_pkg::*;
(
	input  logic          sys_clk,
	input  logic          sys_rst_n,
	input  logic          line,
	output uart_rx_beat_t rx_beat
);

	localparam int CPB   = `CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CPB);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t        state;
	logic [1:0]       sync_q;
	logic             rx_s;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shreg;
	logic             half_bit;
	logic             full_bit;
	logic             beat_vld;
	uart_byte_t       beat_data;
	logic             beat_err;

	assign rx_s     = sync_q[1];
	assign half_bit = (clk_cnt == CNT_W'(CPB / 2 - 1));
	assign full_bit = (clk_cnt == CNT_W'(CPB - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			sync_q   <= 2'b11;
			state    <= RX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			beat_vld <= 1'b0;
		end else begin
			sync_q   <= {sync_q[0], line};
			beat_vld <= 1'b0;
			clk_cnt  <= clk_cnt + CNT_W'(1);
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (!rx_s)
						state <= RX_START;
				end
				// confirm the start bit in its middle, else treat as a glitch
				RX_START: if (half_bit) begin
					clk_cnt <= '0;
					bit_idx <= '0;
					state   <= rx_s ? RX_IDLE : RX_DATA;
				end
				RX_DATA: if (full_bit) begin
					clk_cnt <= '0;
					bit_idx <= bit_idx + 3'd1;
					if (bit_idx == 3'd7)
						state <= RX_STOP;
				end
				RX_STOP: if (full_bit) begin
					clk_cnt  <= '0;
					beat_vld <= 1'b1;
					state    <= RX_IDLE;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// lsb arrives first, shift in from the top
	always_ff @(posedge sys_clk) begin
		if (state == RX_DATA && full_bit)
			shreg <= {rx_s, shreg[7:1]};
		if (state == RX_STOP && full_bit) begin
			beat_data <= shreg;
			beat_err  <= !rx_s;
		end
	end

	assign rx_beat.vld      = beat_vld;
	assign rx_beat.data     = beat_data;
	assign rx_beat.stop_err = beat_err;

endmodule

/* hdl/uart_tx.sv */
//********************************************************************
// uart byte serializer
// start bit, eight data bits lsb first, one stop bit
//********************************************************************
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx
	import uart_pkg::*;
(
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       byte_req,
	input  uart_byte_t byte_data,
	output logic       line,
	output logic       byte_done
);

	localparam int CPB   = `CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CPB);

	logic             busy;
	logic [CNT_W-1:0] clk_cnt;
	// 0 start, 1..8 data, 9 stop
	logic [3:0]       bit_idx;
	// remaining data bits with the stop bit on top
	logic [8:0]       shreg;
	logic             bit_end;
	logic             last_cycle;
	logic             accept;

	assign bit_end    = (clk_cnt == CNT_W'(CPB - 1));
	assign last_cycle = busy && bit_end && (bit_idx == 4'd9);
	// the final stop cycle already counts as idle, bytes chain without a gap
	assign accept     = byte_req && (!busy || last_cycle);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_idx <= '0;
			line    <= 1'b1;
		end else if (accept) begin
			busy    <= 1'b1;
			clk_cnt <= '0;
			bit_idx <= '0;
			line    <= 1'b0;
		end else if (busy) begin
			if (bit_end) begin
				clk_cnt <= '0;
				if (bit_idx == 4'd9) begin
					busy <= 1'b0;
					line <= 1'b1;
				end else begin
					bit_idx <= bit_idx + 4'd1;
					line    <= shreg[0];
				end
			end else begin
				clk_cnt <= clk_cnt + CNT_W'(1);
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			shreg <= {1'b1, byte_data};
		end else if (busy && bit_end && bit_idx != 4'd9) begin
			shreg <= {1'b1, shreg[8:1]};
		end
	end

	// done lands one cycle ahead of the stop bit end so the next request
	// meets the last stop cycle
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			byte_done <= 1'b0;
		end else begin
			byte_done <= busy && (bit_idx == 4'd9) && (clk_cnt == CNT_W'(CPB - 3));
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# builds the uart framing testbench with Verilator, runs it and checks the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f files.f --top-module tb_uart_frame \
	--Mdir obj_dir -o tb_uart_frame &&
out="$(./obj_dir/tb_uart_frame)" ||
{ echo "build or run failed"; exit 1; }
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF "Simulation finished: PASS" || exit 1

/* sim/tb_uart_frame.sv */
//********************************************************************
// testbench for the uart string framing subsystem
// loopback and bit-banged frames, checked by assertions
//********************************************************************
`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart_frame
	import frame_pkg::*;
();

	localparam int         CPB             = `CLKS_PER_BIT;
	localparam int         BYTE_CYCLES     = 10 * CPB;
	localparam int         FRAME_CYCLES    = (`MAX_CHARS + 4) * BYTE_CYCLES;
	localparam int         IDX_W           = $clog2(`MAX_CHARS);
	localparam logic [7:0] MARK            = `FRAME_MARK;
	// all tests together stay below twelve full-size frames of bytes
	localparam int         TEST_BYTES      = 12 * (`MAX_CHARS + 4);
	localparam int         WATCHDOG_CYCLES = TEST_BYTES * BYTE_CYCLES + 5000;

	logic       sys_clk;
	logic       sys_rst_n;
	logic       tx_req;
	frame_msg_t tx_msg;
	logic       tx_busy;
	logic       tx_done;
	frame_msg_t rx_msg;
	logic       rx_busy;
	logic       rx_done;
	logic       rx_err;
	logic       uart_tx_port;
	logic       uart_rx_port;
	logic       use_bb;
	logic       bb_line;

	int          err_cnt    = 0;
	int          rx_frames  = 0;
	int          rx_errs    = 0;
	int          err_expect = 0;
	string       test_name  = "reset";
	frame_msg_t  exp_q[$];
	frame_msg_t  exp_msg;
	frame_msg_t  last_msg;
	frame_msg_t  prev_msg;
	logic [7:0]  bang_q[$];
	logic [31:0] lfsr_q     = 32'hecc6_417f;
	logic        tx_pending = 1'b0;
	longint      cyc        = 0;
	longint      req_cyc    = 0;
	longint      exp_cyc    = 0;
	int          req_len    = 0;

	// loopback or bit-banged line into the receiver
	assign uart_rx_port = use_bb ? bb_line : uart_tx_port;

	uart_frame_top u_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_req       (tx_req),
		.tx_msg       (tx_msg),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_msg       (rx_msg),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_err       (rx_err),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	task automatic report_value(input logic [159:0] exp, input logic [159:0] act);
		err_cnt++;
		$display("ERR %s expected %0h actual %0h", test_name, exp, act);
	endtask

	task automatic report_event(input string what);
		err_cnt++;
		$display("%s: %s", test_name, what);
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v      = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// content never carries the marker
	function automatic logic [7:0] rand_char();
		logic [7:0] b;
		b = 8'(rand_bits(8));
		if (b == MARK)
			b = b ^ 8'h40;
		return b;
	endfunction

	function automatic frame_msg_t random_msg(input int len);
		frame_msg_t m;
		int         i;
		m     = '0;
		m.len = frame_len_t'(len);
		for (i = 0; i < len; i++)
			m.chars[IDX_W'(i)] = rand_char();
		return m;
	endfunction

	task automatic push_marks();
		bang_q.push_back(MARK);
		bang_q.push_back(MARK);
	endtask

	task automatic push_msg_frame(input frame_msg_t msg);
		int i;
		push_marks();
		for (i = 0; i < int'(msg.len); i++)
			bang_q.push_back(msg.chars[IDX_W'(i)]);
		push_marks();
	endtask

	// start bit, data lsb first, stop bit, then idle after a broken stop
	task automatic bang_byte(input logic [7:0] data, input logic bad_stop);
		logic [9:0] bits;
		int         i;
		bits = {~bad_stop, data, 1'b0};
		for (i = 0; i < 10; i++) begin
			bb_line <= bits[0];
			bits = bits >> 1;
			repeat (CPB) @(posedge sys_clk);
		end
		if (bad_stop) begin
			bb_line <= 1'b1;
			repeat (2 * CPB) @(posedge sys_clk);
		end
	endtask

	task automatic bang_stream(input int bad_idx);
		int i;
		for (i = 0; i < bang_q.size(); i++)
			bang_byte(bang_q[i], i == bad_idx);
		bang_q.delete();
	endtask

	task automatic start_tx(input frame_msg_t msg);
		tx_msg <= msg;
		tx_req <= 1'b1;
		@(posedge sys_clk);
		tx_req <= 1'b0;
	endtask

	task automatic wait_tx_done();
		int n;
		n = 0;
		while (!tx_done && n < FRAME_CYCLES + 16) begin
			@(posedge sys_clk);
			n++;
		end
		assert (tx_done) else report_event("tx_done did not arrive");
	endtask

	task automatic wait_rx_drain();
		int n;
		n = 0;
		while ((exp_q.size() != 0 || err_expect != 0) && n < 4 * BYTE_CYCLES) begin
			@(posedge sys_clk);
			n++;
		end
		assert (exp_q.size() == 0 && err_expect == 0) else begin
			report_event("receiver did not report the expected frames or errors");
			exp_q.delete();
			err_expect = 0;
		end
	endtask

	task automatic send_loopback(input frame_msg_t msg);
		exp_q.push_back(msg);
		start_tx(msg);
		wait_tx_done();
		wait_rx_drain();
	endtask

	// transmit timing from the accepted request to tx_done
	always @(posedge sys_clk) begin
		if (sys_rst_n) begin
			if (tx_pending) begin
				if (tx_done) begin
					exp_cyc = longint'((req_len + 4) * BYTE_CYCLES + 1);
					assert (cyc - req_cyc == exp_cyc)
						else report_value(160'(exp_cyc), 160'(cyc - req_cyc));
					tx_pending = 1'b0;
				end else begin
					assert (tx_busy) else report_event("tx_busy dropped inside a frame");
				end
			end else begin
				assert (!tx_done) else report_event("tx_done without a request");
			end
			if (tx_req && !tx_busy) begin
				tx_pending = 1'b1;
				req_cyc    = cyc;
				req_len    = int'(tx_msg.len);
			end
		end
		cyc = cyc + 1;
	end

	// received frames against the model queue
	always @(posedge sys_clk) begin
		if (sys_rst_n) begin
			if (rx_done) begin
				rx_frames++;
				if (exp_q.size() == 0) begin
					report_event("rx_done with no frame outstanding");
				end else begin
					exp_msg = exp_q.pop_front();
					assert (rx_msg == exp_msg) else report_value(160'(exp_msg), 160'(rx_msg));
					last_msg = exp_msg;
				end
			end
			if (rx_err) begin
				rx_errs++;
				assert (err_expect > 0) else report_event("unexpected rx_err");
				if (err_expect > 0)
					err_expect--;
			end
			assert (rx_done || rx_msg === prev_msg)
				else report_event("rx_msg changed without rx_done");
		end
		prev_msg = rx_msg;
	end

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n) tx_done |-> !tx_busy)
		else report_event("tx_busy still high with tx_done");
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n) (rx_done || rx_err) |-> !rx_busy)
		else report_event("rx_busy still high at the end of a frame");
	// a frame that ends or breaks was open in the cycle before
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(rx_done || rx_err) |-> $past(rx_busy))
		else report_event("rx_busy was not high before the end of a frame");
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n) rx_done |-> !rx_err)
		else report_event("rx_done and rx_err in the same cycle");

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge sys_clk);
		$display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		frame_msg_t msg;
		int         i;
		sys_rst_n = 1'b0;
		tx_req    = 1'b0;
		tx_msg    = '0;
		use_bb    = 1'b0;
		bb_line   = 1'b1;
		repeat (3) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(posedge sys_clk);
		assert ({tx_busy, tx_done, rx_busy, rx_done, rx_err, uart_tx_port} == 6'b000001)
			else report_value(160'(6'b000001),
				160'({tx_busy, tx_done, rx_busy, rx_done, rx_err, uart_tx_port}));

		// shortest, longest, then random lengths
		test_name = "loopback";
		send_loopback(random_msg(0));
		send_loopback(random_msg(`MAX_CHARS));
		for (i = 0; i < 4; i++)
			send_loopback(random_msg(int'(rand_bits(5)) % (`MAX_CHARS + 1)));

		// second request lands while busy and must be dropped
		test_name = "tx_timing";
		msg = random_msg(int'(rand_bits(5)) % (`MAX_CHARS + 1));
		exp_q.push_back(msg);
		start_tx(msg);
		repeat (100) @(posedge sys_clk);
		start_tx(random_msg(3));
		wait_tx_done();
		wait_rx_drain();
		repeat (FRAME_CYCLES) @(posedge sys_clk);

		test_name = "stray_bytes";
		use_bb <= 1'b1;
		@(posedge sys_clk);
		bang_q.push_back(8'h61);
		bang_q.push_back(8'h5a);
		bang_q.push_back(8'h30);
		bang_q.push_back(MARK);
		bang_q.push_back(8'h71);
		msg = random_msg(5);
		push_msg_frame(msg);
		exp_q.push_back(msg);
		bang_stream(-1);
		wait_rx_drain();

		// one byte past the limit
		test_name = "overflow";
		push_marks();
		repeat (`MAX_CHARS + 1) bang_q.push_back(rand_char());
		push_marks();
		err_expect = 1;
		bang_stream(-1);
		wait_rx_drain();
		assert (rx_msg == last_msg) else report_value(160'(last_msg), 160'(rx_msg));

		// third content byte carries the broken stop bit
		test_name = "stop_error";
		push_marks();
		repeat (6) bang_q.push_back(rand_char());
		push_marks();
		err_expect = 1;
		bang_stream(4);
		wait_rx_drain();
		use_bb <= 1'b0;
		@(posedge sys_clk);
		send_loopback(random_msg(int'(rand_bits(5)) % (`MAX_CHARS + 1)));

		$display("errors %0d, frames received %0d, rx_err pulses %0d",
			err_cnt, rx_frames, rx_errs);
		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
